// ==== Makefile ====
TOP = tb_tile_layer

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tile_layer_top.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tile_layer_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tile_layer_top -f tile_layer_top.f

clean:
	rm -rf obj_dir sim.log

// ==== line_buffer.sv ====
// line buffer: 512-entry pixel RAM, renderer write port and registered read port
`timescale 1ns/1ns

module line_buffer import tile_pkg::*; (
    input  logic        clk,
    input  buf_wr_t     wr,
    input  logic [8:0]  pix_addr,
    output logic [10:0] pix_data
);

    ////////////////////
    // storage, one {group, pal, colour} entry per pixel
    logic [10:0] mem [0:511];

    // renderer side
    always_ff @(posedge clk) begin
        if (wr.wr) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // display side, one cycle of latency
    always_ff @(posedge clk) begin
        pix_data <= mem[pix_addr];
    end

endmodule

// ==== tb_tile_layer.sv ====
// tile layer testbench with memory models, APB tasks, line model and directed tests
`timescale 1ns/1ns

module tb_tile_layer import tile_pkg::*; ();

    localparam int LINE_W     = 384;
    localparam int MAX_CYCLES = 4 * LINE_W * 40;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    vram_req_t   vram_req;
    vram_word_u  vram_data = '0;
    logic        vram_ok   = 1'b0;
    rom_req_t    rom_req;
    logic [31:0] rom_data  = '0;
    logic        rom_ok    = 1'b0;
    logic [8:0]  pix_addr;
    logic [10:0] pix_data;
    logic        done;

    bit          flips_on;          // flip bits allowed in the VRAM words
    bit          stalls_on;         // random wait states on both memories
    logic [20:0] tb_banks [4];
    logic [10:0] exp_line [512];
    logic [10:0] got_line [512];
    logic [10:0] ref_line [512];
    int          value_errs = 0;
    int          other_errs = 0;
    int          starts     = 0;
    int          done_rises = 0;
    logic        done_q     = 1'b0;
    int          cycles;

    logic        v_act;
    logic [16:0] v_addr;
    int          v_wait;
    logic        r_act;
    logic [20:0] r_key;
    int          r_wait;

    tile_layer_top #(.LINE_W(LINE_W)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // memory contents hashed from the full address
    function automatic logic [15:0] vram_word(input logic [16:0] a);
        logic [31:0] h;
        h = {15'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        return flips_on ? h[15:0] : (h[15:0] & 16'hff9f);   // bits 6:5 are the flips
    endfunction

    function automatic logic [31:0] rom_word(input logic [20:0] a);
        logic [31:0] h;
        h = ({11'd0, a} ^ 32'h5bd1e995) * 32'h2c1b3c6d;
        return h ^ (h >> 13);
    endfunction

    // VRAM and ROM models restart the wait on a new address and hold ok until cs drops
    always @(posedge clk) begin
        if (rst || !vram_req.cs) begin
            vram_ok <= 1'b0;
            v_act   <= 1'b0;
        end else if (!v_act || vram_req.addr != v_addr) begin
            vram_ok <= 1'b0;
            v_act   <= 1'b1;
            v_addr  <= vram_req.addr;
            v_wait  <= stalls_on ? int'($urandom_range(0, 3)) : 0;
        end else if (v_wait != 0) begin
            v_wait <= v_wait - 1;
        end else begin
            vram_ok   <= 1'b1;
            vram_data <= vram_word(v_addr);
        end
    end

    always @(posedge clk) begin
        if (rst || !rom_req.cs) begin
            rom_ok <= 1'b0;
            r_act  <= 1'b0;
        end else if (!r_act || {rom_req.half, rom_req.addr} != r_key) begin
            rom_ok <= 1'b0;
            r_act  <= 1'b1;
            r_key  <= {rom_req.half, rom_req.addr};     // half folded into the row address
            r_wait <= stalls_on ? int'($urandom_range(0, 3)) : 0;
        end else if (r_wait != 0) begin
            r_wait <= r_wait - 1;
        end else begin
            rom_ok   <= 1'b1;
            rom_data <= rom_word(r_key);
        end
    end

    always @(posedge clk) begin
        done_q <= done;
        if (done && !done_q) begin
            done_rises <= done_rises + 1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            value_errs++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                 // data and error settle in the access phase
        data = prdata;
        err  = pslverr;
        expect_eq(32'(pready), 32'd1, "pready in the access phase");
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [20:0] make_bank(input logic en, input logic [2:0] layers,
                                             input logic [5:0] lo, input logic [5:0] hi,
                                             input logic [3:0] off);
        return {1'b0, off, hi, lo, layers, en};
    endfunction

    // first enabled entry for this size whose range holds the upper code bits
    function automatic bit bank_match(input logic [5:0] hi, input int size,
                                      output logic [3:0] off);
        off = 4'd0;
        for (int i = 0; i < 4; i++) begin
            if (tb_banks[i][0] && tb_banks[i][1 + size] &&
                hi >= tb_banks[i][9:4] && hi <= tb_banks[i][15:10]) begin
                off = tb_banks[i][19:16];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // one bit per byte plane with the top byte as the most significant plane
    function automatic logic [3:0] pixel_bits(input logic [31:0] w, input int k);
        logic [3:0] c;
        for (int p = 0; p < 4; p++) begin
            c[3 - p] = w[31 - 8 * p - k];
        end
        return c;
    endfunction

    ////////////////////
    // reference line walked tile by tile from the leftmost partial tile
    task automatic build_expected(input int size, input int base, input int hpos,
                                  input int vpos, input int vrender);
        int          w;
        int          words;
        int          vn;
        int          col;
        int          slot;
        int          r;
        int          widx;
        int          pre;
        int          addr;
        logic [16:0] a;
        logic [15:0] code;
        logic [15:0] attr;
        logic [31:0] rw;
        logic [3:0]  off;
        logic [3:0]  colour;
        bit          mapped;
        w     = 8 << size;
        words = w / 8;
        vn    = (vpos + vrender) % 2048;
        col   = (hpos / w) % 64;
        slot  = -(hpos % w);
        while (slot < LINE_W) begin
            a      = 17'(((base >> 1) & 'h1ff) * 256 + (col * 64 + (vn / w) % 64) * 2);
            code   = vram_word(a);
            attr   = vram_word(a + 17'd1);
            mapped = bank_match(code[15:10], size, off);
            r      = (attr[6]) ? w - 1 - (vn % w) : vn % w;
            for (int wd = 0; wd < words; wd++) begin
                widx = attr[5] ? words - 1 - wd : wd;       // right to left when hflip
                pre  = (int'(code) * 32 + r * 4 + widx) % (1 << 20);
                addr = mapped ? ((pre & 'hffff) | (int'(off) << 16)) : pre;
                rw   = rom_word({widx[0], 20'(addr)});
                for (int k = 0; k < 8; k++) begin
                    colour = mapped ? pixel_bits(rw, attr[5] ? 7 - k : k) : 4'hf;
                    if (slot >= 0 && slot < LINE_W) begin
                        exp_line[slot] = {attr[8:7], attr[4:0], colour};
                    end
                    slot++;
                end
            end
            col = (col + 1) % 64;
        end
    endtask

    task automatic run_line(input int size, input int base, input int hpos,
                            input int vpos, input int vrender);
        logic [31:0] st;
        logic        err;
        for (int i = 0; i < 4; i++) begin
            apb_write(BANK0 + 8'(4 * i), {11'd0, tb_banks[i]});
        end
        apb_write(VRAM_BASE, base);
        apb_write(HPOS, hpos);
        apb_write(VPOS, vpos);
        apb_write(VRENDER, vrender);
        apb_write(CTRL, {29'd0, 2'(size), 1'b1});
        starts++;
        st = '0;
        while (!st[1]) begin
            apb_read(STATUS, st, err);
        end
        build_expected(size, base, hpos, vpos, vrender);
        for (int i = 0; i < LINE_W; i++) begin
            @(posedge clk);
            pix_addr <= 9'(i);
            @(posedge clk);
            @(negedge clk);
            got_line[i] = pix_data;
            expect_eq(32'(pix_data), 32'(exp_line[i]), $sformatf("size %0d pixel %0d", size, i));
        end
        assert (done_rises == starts) else begin
            other_errs++;
            $display("done rose %0d times over %0d starts", done_rises, starts);
        end
    endtask

    task automatic default_banks();
        tb_banks[0] = make_bank(1'b1, 3'b111, 6'd0, 6'd63, 4'h2);
        tb_banks[1] = '0;
        tb_banks[2] = '0;
        tb_banks[3] = '0;
    endtask

    ////////////////////
    task automatic test_registers();
        logic [7:0]  offs  [8];
        logic [31:0] masks [8];
        logic [31:0] pat;
        logic [31:0] d;
        logic        err;
        offs  = '{VRAM_BASE, HPOS, VPOS, VRENDER, BANK0, BANK1, BANK2, BANK3};
        masks = '{32'hffff, 32'h7ff, 32'h7ff, 32'h1ff,
                  32'h1fffff, 32'h1fffff, 32'h1fffff, 32'h1fffff};
        apb_read(STATUS, d, err);
        expect_eq(d, 32'd0, "STATUS after reset");
        apb_write(CTRL, 32'h4);             // size 32x32 without start
        apb_read(CTRL, d, err);
        expect_eq(d, 32'h4, "CTRL readback");
        for (int i = 0; i < 8; i++) begin
            pat = 32'h9c5a3e71 + 32'(i) * 32'h01234567;
            apb_write(offs[i], pat);
            apb_read(offs[i], d, err);
            expect_eq(d, pat & masks[i], $sformatf("register %h readback", offs[i]));
            expect_eq(32'(err), 32'd0, $sformatf("pslverr on %h", offs[i]));
        end
        apb_read(8'h18, d, err);
        expect_eq(32'(err), 32'd1, "pslverr on undecoded 18");
        apb_read(8'h40, d, err);
        expect_eq(32'(err), 32'd1, "pslverr on undecoded 40");
    endtask

    task automatic test_plain_8x8();
        flips_on = 1'b0;
        default_banks();
        run_line(0, 'h0000, 'h000, 'h000, 5);
        flips_on = 1'b1;
    endtask

    task automatic test_scrolled();
        default_banks();
        run_line(1, 'h0202, 'h1a3, 'h047, 100);
        run_line(2, 'h0400, 'h7f5, 'h3ff, 'h1ff);  // column wraps past 63
    endtask

    task automatic test_bank_table();
        tb_banks[0] = make_bank(1'b1, 3'b111, 6'd0, 6'd15, 4'h3);
        tb_banks[1] = make_bank(1'b0, 3'b111, 6'd16, 6'd63, 4'h5);   // disabled
        tb_banks[2] = make_bank(1'b1, 3'b001, 6'd10, 6'd40, 4'h7);   // loses to entry 0
        tb_banks[3] = make_bank(1'b1, 3'b010, 6'd41, 6'd50, 4'h9);   // 16x16 only
        run_line(0, 'h0010, 'h013, 'h021, 40);
        run_line(1, 'h0010, 'h0a0, 'h021, 41);
    endtask

    task automatic test_stalls();
        default_banks();
        stalls_on = 1'b0;
        run_line(1, 'h0100, 'h029, 'h013, 77);
        for (int i = 0; i < LINE_W; i++) begin
            ref_line[i] = got_line[i];
        end
        stalls_on = 1'b1;
        run_line(1, 'h0100, 'h029, 'h013, 77);
        for (int i = 0; i < LINE_W; i++) begin
            expect_eq(32'(got_line[i]), 32'(ref_line[i]), $sformatf("stalled pixel %0d", i));
        end
        stalls_on = 1'b0;
    endtask

    ////////////////////
    initial begin
        void'($urandom(32'h51ad87f1));
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pix_addr  = '0;
        flips_on  = 1'b1;
        stalls_on = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_registers();
        test_plain_8x8();
        test_scrolled();
        test_bank_table();
        test_stalls();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tile_bank_map.sv ====
// graphics ROM bank mapper: priority search of the four-entry bank table
`timescale 1ns/1ns

module tile_bank_map import tile_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bank_table_t banks,
    input  tile_size_e  size,
    input  logic [5:0]  code_hi,
    input  logic        lookup,
    output logic [3:0]  offset,
    output logic [3:0]  mask,
    output logic        unmapped
);

    logic       hit;
    logic [3:0] hit_offset;
    logic [2:0] layer_sel;

    assign layer_sel = size_onehot(size);

    // lowest index wins when entries overlap
    always_comb begin
        hit        = 1'b0;
        hit_offset = 4'd0;
        for (int i = 0; i < 4; i++) begin
            if (!hit && banks[i].en && (banks[i].layers & layer_sel) != 3'd0 &&
                code_hi >= banks[i].code_lo && code_hi <= banks[i].code_hi) begin
                hit        = 1'b1;
                hit_offset = banks[i].offset;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset   <= 4'd0;
            mask     <= 4'hf;
            unmapped <= 1'b0;
        end else if (lookup) begin
            offset   <= hit ? hit_offset : 4'd0;
            mask     <= hit ? 4'h0 : 4'hf;  // no match keeps the raw address
            unmapped <= !hit;
        end
    end

endmodule

// ==== tile_fetch.sv ====
// line fetch engine: map reads, bank lookup, ROM word fetch and pixel serializer
`timescale 1ns/1ns

module tile_fetch import tile_pkg::*; #(
    parameter int LINE_W = LINE_W_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  layer_cfg_t  cfg,
    input  vram_word_u  vram_data,
    input  logic        vram_ok,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    input  logic [3:0]  offset,
    input  logic [3:0]  mask,
    input  logic        unmapped,
    output vram_req_t   vram_req,
    output rom_req_t    rom_req,
    output logic        lookup,
    output logic [5:0]  code_hi,
    output buf_wr_t     wr,
    output logic        busy,
    output logic        done
);

    typedef enum logic [3:0] {
        S_IDLE, S_TILE, S_CODE, S_GAP, S_ATTR, S_ROMSET, S_ROMWAIT, S_PIX, S_DONE
    } state_e;

    localparam logic signed [10:0] LAST_SLOT = 11'(LINE_W - 1);

    state_e             state;
    logic [10:0]        vn;         // map line, vpos + vrender
    logic [5:0]         col;        // map column, wraps at 64
    logic signed [10:0] slot;       // buffer position of the next pixel
    logic [1:0]         word_cnt;
    logic [2:0]         pix_k;
    logic [15:0]        code;
    tile_attr_t         attr;
    logic [31:0]        pxl;

    logic [5:0]  width;
    logic [2:0]  shift;
    logic [4:0]  wmask;
    logic [1:0]  last_word;
    logic [5:0]  map_row;
    logic [16:0] map_addr;
    logic [4:0]  row;
    logic [1:0]  word_idx;
    logic [19:0] rom_pre;
    logic [19:0] rom_addr;
    logic [3:0]  colour;
    logic        in_line;

    ////////////////////
    // address arithmetic
    assign width     = tile_width(cfg.size);
    assign shift     = tile_shift(cfg.size);
    assign wmask     = 5'(width - 6'd1);
    assign last_word = 2'((width >> 3) - 6'd1);    // width/8 words per tile row
    assign map_row   = 6'(vn >> shift);

    // column major map, two words per entry
    assign map_addr = {cfg.vram_base[9:1], 8'd0} + {4'd0, col, map_row, 1'b0};

    assign row      = (vn[4:0] & wmask) ^ ({5{attr.vflip}} & wmask);
    assign word_idx = attr.hflip ? last_word - word_cnt : word_cnt;
    assign rom_pre  = {code[14:0], 5'd0} + {13'd0, row, 2'd0} + {18'd0, word_idx};
    assign rom_addr = ({mask, 16'hffff} & rom_pre) | {offset, 16'd0};

    assign colour  = unmapped ? 4'hf : plane_pixel(pxl, pix_k ^ {3{attr.hflip}});
    assign in_line = (slot >= 0) && (slot <= LAST_SLOT);
    assign code_hi = code[15:10];

    // tile data captured as it arrives
    always_ff @(posedge clk) begin
        if (state == S_CODE && vram_ok) begin
            code <= vram_data.code;
        end
        if (state == S_ATTR && vram_ok) begin
            attr <= vram_data.attr;
        end
        if (state == S_ROMWAIT && rom_ok) begin
            pxl <= rom_data;
        end
    end

    ////////////////////
    // main FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_IDLE;
            vram_req <= '0;
            rom_req  <= '0;
            wr       <= '0;
            lookup   <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            vn       <= 11'd0;
            col      <= 6'd0;
            slot     <= 11'sd0;
            word_cnt <= 2'd0;
            pix_k    <= 3'd0;
        end else begin
            wr.wr  <= 1'b0;
            lookup <= 1'b0;
            if (cfg.start) begin                // also restarts a running line
                vram_req.cs <= 1'b0;
                rom_req.cs  <= 1'b0;
                busy        <= 1'b1;
                done        <= 1'b0;
                vn          <= cfg.vpos + {2'd0, cfg.vrender};
                col         <= 6'(cfg.hpos >> shift);
                slot        <= 11'sd0 - $signed({6'd0, cfg.hpos[4:0] & wmask});
                state       <= S_TILE;
            end else begin
                case (state)
                    S_TILE: begin
                        vram_req <= '{cs: 1'b1, addr: map_addr};
                        state    <= S_CODE;
                    end
                    S_CODE: if (vram_ok) begin
                        lookup           <= 1'b1;
                        vram_req.addr[0] <= 1'b1;   // attribute word, cs stays up
                        state            <= S_GAP;
                    end
                    S_GAP: state <= S_ATTR;         // lets ok drop for the new address
                    S_ATTR: if (vram_ok) begin
                        vram_req.cs <= 1'b0;
                        word_cnt    <= 2'd0;
                        state       <= S_ROMSET;
                    end
                    S_ROMSET: begin
                        rom_req <= '{cs: 1'b1, half: word_idx[0], addr: rom_addr};
                        state   <= S_ROMWAIT;
                    end
                    S_ROMWAIT: if (rom_ok) begin
                        rom_req.cs <= 1'b0;
                        pix_k      <= 3'd0;
                        state      <= S_PIX;
                    end
                    S_PIX: begin
                        wr    <= '{wr: in_line, addr: slot[8:0],
                                   data: {attr.group, attr.pal, colour}};
                        slot  <= slot + 11'sd1;
                        pix_k <= pix_k + 3'd1;
                        if (slot == LAST_SLOT) begin
                            state <= S_DONE;
                        end else if (pix_k == 3'd7) begin
                            if (word_cnt == last_word) begin
                                col   <= col + 6'd1;
                                state <= S_TILE;
                            end else begin
                                word_cnt <= word_cnt + 2'd1;
                                state    <= S_ROMSET;
                            end
                        end
                    end
                    S_DONE: begin
                        busy  <= 1'b0;
                        done  <= 1'b1;              // held until the next start
                        state <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

// ==== tile_layer_sva.sv ====
// concurrent checks on the fetch engine memory handshakes and line buffer writes
`timescale 1ns/1ns

module tile_layer_sva import tile_pkg::*; (
    input logic      clk,
    input logic      rst,
    input vram_req_t vram_req,
    input logic      vram_ok,
    input rom_req_t  rom_req,
    input logic      rom_ok,
    input buf_wr_t   wr,
    input logic      busy,
    input logic      done
);

    ////////////////////
    // a request stays up and steady until the memory answers
    vram_cs_hold: assert property (@(posedge clk) disable iff (rst)
        vram_req.cs && !vram_ok |=> vram_req.cs)
        else $error("vram cs dropped before vram_ok");

    vram_addr_hold: assert property (@(posedge clk) disable iff (rst)
        vram_req.cs && !vram_ok |=> $stable(vram_req.addr))
        else $error("vram address moved while waiting");

    rom_cs_hold: assert property (@(posedge clk) disable iff (rst)
        rom_req.cs && !rom_ok |=> rom_req.cs)
        else $error("rom cs dropped before rom_ok");

    rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rom_req.cs && !rom_ok |=> $stable(rom_req))      // half included
        else $error("rom address moved while waiting");

    no_wr_when_done: assert property (@(posedge clk) disable iff (rst) done |-> !wr.wr)
        else $error("line buffer written after done");

    // done comes up one cycle after the last buffer write and never together with busy
    done_after_last_wr: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(wr.wr) && !busy)
        else $error("done rose without a final buffer write or with busy high");

endmodule

bind tile_fetch tile_layer_sva sva_i (
    .clk      (clk),
    .rst      (rst),
    .vram_req (vram_req),
    .vram_ok  (vram_ok),
    .rom_req  (rom_req),
    .rom_ok   (rom_ok),
    .wr       (wr),
    .busy     (busy),
    .done     (done)
);

// ==== tile_layer_top.f ====
tile_pkg.sv
tile_regs.sv
tile_bank_map.sv
tile_fetch.sv
line_buffer.sv
tile_layer_top.sv
tile_layer_sva.sv
tb_tile_layer.sv

// ==== tile_layer_top.sv ====
// scroll layer top: register block, bank mapper, fetch engine and line buffer
`timescale 1ns/1ns

module tile_layer_top import tile_pkg::*; #(
    parameter int LINE_W = LINE_W_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    // APB control port
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // video RAM
    output vram_req_t   vram_req,
    input  vram_word_u  vram_data,
    input  logic        vram_ok,
    // graphics ROM
    output rom_req_t    rom_req,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    // line read out
    input  logic [8:0]  pix_addr,
    output logic [10:0] pix_data,
    output logic        done
);

    layer_cfg_t  cfg;
    bank_table_t banks;
    buf_wr_t     wr;
    logic        busy;
    logic        lookup;
    logic [5:0]  code_hi;
    logic [3:0]  offset;
    logic [3:0]  mask;
    logic        unmapped;

    tile_regs regs_i (
        .clk     (clk),      .rst      (rst),
        .paddr   (paddr),    .psel     (psel),
        .penable (penable),  .pwrite   (pwrite),
        .pwdata  (pwdata),   .busy     (busy),
        .done    (done),     .prdata   (prdata),
        .pready  (pready),   .pslverr  (pslverr),
        .cfg     (cfg),      .banks    (banks)
    );

    tile_bank_map map_i (
        .clk      (clk),      .rst     (rst),
        .banks    (banks),    .size    (cfg.size),
        .code_hi  (code_hi),  .lookup  (lookup),
        .offset   (offset),   .mask    (mask),
        .unmapped (unmapped)
    );

    tile_fetch #(.LINE_W(LINE_W)) fetch_i (
        .clk      (clk),       .rst       (rst),
        .cfg      (cfg),       .vram_data (vram_data),
        .vram_ok  (vram_ok),   .rom_data  (rom_data),
        .rom_ok   (rom_ok),    .offset    (offset),
        .mask     (mask),      .unmapped  (unmapped),
        .vram_req (vram_req),  .rom_req   (rom_req),
        .lookup   (lookup),    .code_hi   (code_hi),
        .wr       (wr),        .busy      (busy),
        .done     (done)
    );

    line_buffer buf_i (
        .clk      (clk),
        .wr       (wr),
        .pix_addr (pix_addr),
        .pix_data (pix_data)
    );

endmodule

// ==== tile_pkg.sv ====
// tile layer types, register offsets and tile/pixel helper functions
package tile_pkg;

    localparam int LINE_W_DEFAULT = 384;    // visible pixels per line

    // APB register offsets
    localparam logic [7:0] CTRL      = 8'h00;
    localparam logic [7:0] STATUS    = 8'h04;
    localparam logic [7:0] VRAM_BASE = 8'h08;
    localparam logic [7:0] HPOS      = 8'h0C;
    localparam logic [7:0] VPOS      = 8'h10;
    localparam logic [7:0] VRENDER   = 8'h14;
    localparam logic [7:0] BANK0     = 8'h20;
    localparam logic [7:0] BANK1     = 8'h24;
    localparam logic [7:0] BANK2     = 8'h28;
    localparam logic [7:0] BANK3     = 8'h2C;

    typedef enum logic [1:0] {
        TS_8  = 2'd0,
        TS_16 = 2'd1,
        TS_32 = 2'd2
    } tile_size_e;

    typedef struct packed {
        tile_size_e  size;
        logic [15:0] vram_base;     // bits 9:1 pick the map in 256-word units
        logic [10:0] hpos;
        logic [10:0] vpos;
        logic [8:0]  vrender;       // line being drawn
        logic        start;
    } layer_cfg_t;

    typedef struct packed {
        logic       rsvd;
        logic [3:0] offset;         // replaces rom address bits 19:16
        logic [5:0] code_hi;
        logic [5:0] code_lo;
        logic [2:0] layers;         // bit 0 = 8x8, bit 1 = 16x16, bit 2 = 32x32
        logic       en;
    } bank_entry_t;

    typedef bank_entry_t [3:0] bank_table_t;

    typedef struct packed {
        logic [6:0] unused;
        logic [1:0] group;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    // first read of a map entry is the code, second one the attributes
    typedef union packed {
        logic [15:0] code;
        tile_attr_t  attr;
    } vram_word_u;

    typedef struct packed {
        logic        cs;
        logic [16:0] addr;
    } vram_req_t;

    typedef struct packed {
        logic        cs;
        logic        half;
        logic [19:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic        wr;
        logic [8:0]  addr;
        logic [10:0] data;          // {group, pal, colour}
    } buf_wr_t;

    ////////////////////
    function automatic logic [5:0] tile_width(tile_size_e size);
        case (size)
            TS_8:    return 6'd8;
            TS_16:   return 6'd16;
            default: return 6'd32;
        endcase
    endfunction

    function automatic logic [2:0] tile_shift(tile_size_e size);
        case (size)
            TS_8:    return 3'd3;
            TS_16:   return 3'd4;
            default: return 3'd5;
        endcase
    endfunction

    function automatic logic [2:0] size_onehot(tile_size_e size);
        case (size)
            TS_8:    return 3'b001;
            TS_16:   return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

    // pixel k of a planar word, one bit taken from each byte
    function automatic logic [3:0] plane_pixel(logic [31:0] w, logic [2:0] k);
        return {w[31 - k], w[23 - k], w[15 - k], w[7 - k]};
    endfunction

endpackage

// ==== tile_regs.sv ====
// APB register block: layer configuration, bank table, start pulse and status
`timescale 1ns/1ns

module tile_regs import tile_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic        busy,
    input  logic        done,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output layer_cfg_t  cfg,
    output bank_table_t banks
);

    logic        hit;       // offset is decoded
    logic [31:0] rd_val;
    logic        wr_en;

    assign wr_en   = psel && penable && pwrite;
    assign pready  = 1'b1;                      // no wait states
    assign pslverr = psel && penable && !hit;

    ////////////////////
    // read mux
    always_comb begin
        hit    = 1'b1;
        rd_val = '0;
        case (paddr)
            CTRL:      rd_val = {29'd0, cfg.size, 1'b0};  // start always reads back 0
            STATUS:    rd_val = {30'd0, done, busy};
            VRAM_BASE: rd_val = {16'd0, cfg.vram_base};
            HPOS:      rd_val = {21'd0, cfg.hpos};
            VPOS:      rd_val = {21'd0, cfg.vpos};
            VRENDER:   rd_val = {23'd0, cfg.vrender};
            BANK0, BANK1, BANK2, BANK3:
                rd_val = {11'd0, banks[paddr[3:2]]};
            default:   hit = 1'b0;
        endcase
    end

    // sampled in the setup phase, so it is ready during the access phase
    always_ff @(posedge clk) begin
        if (psel && !penable) begin
            prdata <= rd_val;
        end
    end

    ////////////////////
    // write side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg   <= '0;
            banks <= '0;
        end else begin
            cfg.start <= 1'b0;                  // one cycle only
            if (wr_en) begin
                case (paddr)
                    CTRL: begin
                        cfg.start <= pwdata[0];
                        cfg.size  <= tile_size_e'(pwdata[2:1]);
                    end
                    VRAM_BASE: cfg.vram_base <= pwdata[15:0];
                    HPOS:      cfg.hpos      <= pwdata[10:0];
                    VPOS:      cfg.vpos      <= pwdata[10:0];
                    VRENDER:   cfg.vrender   <= pwdata[8:0];
                    BANK0, BANK1, BANK2, BANK3:
                        banks[paddr[3:2]] <= pwdata[20:0];
                    default: ;                  // STATUS is read only
                endcase
            end
        end
    end

endmodule
